/* compile.f */
+incdir+.
mmu_pkg.sv
walk_if.sv
find_first_set.sv
tlb.sv
page_walker.sv
mmu_top.sv
mmu_sva.sv
tb_mmu.sv

/* find_first_set.sv */
module find_first_set
#(
   parameter int LG_N = 2
)
(
   input logic [(1 << LG_N)-1:0] in,
   output logic [LG_N-1:0] y,
   output logic found
);

   localparam int N = 1 << LG_N;

   // scan downwards so the lowest set bit wins
   always_comb
   begin
      y = '0;
      found = 1'b0;
      for (int i = N-1; i >= 0; i--)
      begin
         if (in[i])
         begin
            y = LG_N'(i);
            found = 1'b1;
         end
      end
   end

endmodule

/* mmu_params.svh */
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// physical address bits, Sv39 style
`define PA_WIDTH 56

// virtual address bits
`define VA_WIDTH 39

// log2 of the tlb entry count, 3 or 4 also work
`define TLB_LG_N 2

`endif

/* mmu_pkg.sv */
`include "mmu_params.svh"

package mmu_pkg;

   // encoding follows the walk level, 1 GiB is the top level
   typedef enum logic [1:0]
   {
      PG_1G = 2'd0,
      PG_2M = 2'd1,
      PG_4K = 2'd2
   } pgsize_t;

   // result of a successful walk, handed to the tlb on fill
   typedef struct packed
   {
      // physical page number, address bits above the 4 KiB offset
      logic [`PA_WIDTH-13:0] ppn;
      pgsize_t pgsize;
      logic dirty;
      logic readable;
      logic writable;
      logic executable;
      logic user;
   } page_walk_rsp_t;

endpackage

/* mmu_sva.sv */
module mmu_sva
(
   input logic clk,
   input logic reset,
   input logic req,
   input logic busy,
   input logic resp_valid,
   input logic mem_rd,
   input logic miss,
   input logic fill,
   input logic wfault
);
   timeunit 1ns;
   timeprecision 100ps;

   int rd_count;

   // reads issued since the last miss pulse
   always_ff @(posedge clk)
   begin
      if (reset | miss)
         rd_count <= 0;
      else if (mem_rd)
         rd_count <= rd_count + 1;
   end

   // a walk ends with a single pulse while the tlb waits for it
   a_walk_end: assert property (@(posedge clk) disable iff (reset)
      (fill || wfault) |-> (busy && !(fill && wfault)))
      else $error("walk end outside a pending miss, or fill and fault together");

   a_resp_cause: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> ($past(req) || $past(fill) || $past(wfault)))
      else $error("resp_valid without a request");

   a_resp_not_busy: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> !busy) else $error("busy high with resp_valid");

   a_max_reads: assert property (@(posedge clk) disable iff (reset)
      rd_count <= 3) else $error("more than three reads in one walk");

endmodule

bind mmu_top mmu_sva sva_i (
   .clk(clk), .reset(reset), .req(req), .busy(busy), .resp_valid(resp_valid),
   .mem_rd(mem_rd), .miss(walk_i.miss), .fill(walk_i.fill), .wfault(walk_i.fault)
);

/* mmu_top.sv */
`include "mmu_params.svh"

module mmu_top
(
   input logic clk,
   input logic reset,
   input logic active,
   input logic clear,
   input logic [`PA_WIDTH-13:0] root_ppn,
   input logic req,
   input logic [`VA_WIDTH-1:0] va,
   output logic busy,
   output logic resp_valid,
   output logic hit,
   output logic fault,
   output logic [`PA_WIDTH-1:0] pa,
   output logic dirty,
   output logic readable,
   output logic writable,
   output logic zero_page,
   output logic [63:0] tlb_hits,
   output logic [63:0] tlb_accesses,
   output logic mem_rd,
   output logic [`PA_WIDTH-1:0] mem_addr,
   input logic mem_rvalid,
   input logic [63:0] mem_rdata
);

   // miss, fill and fault between lookup and walker
   walk_if walk_i ();

   tlb #(.LG_N(`TLB_LG_N)) tlb_i (
      .clk(clk), .reset(reset), .active(active), .clear(clear),
      .req(req), .va(va), .walk(walk_i.tlb_side),
      .busy(busy), .resp_valid(resp_valid), .hit(hit), .fault(fault),
      .pa(pa), .dirty(dirty), .readable(readable), .writable(writable),
      .zero_page(zero_page), .tlb_hits(tlb_hits), .tlb_accesses(tlb_accesses)
   );

   page_walker walker_i (
      .clk(clk), .reset(reset), .root_ppn(root_ppn),
      .walk(walk_i.walker_side),
      .mem_rd(mem_rd), .mem_addr(mem_addr),
      .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
   );

endmodule

/* page_walker.sv */
`include "mmu_params.svh"

module page_walker
(
   input logic clk,
   input logic reset,
   input logic [`PA_WIDTH-13:0] root_ppn,
   walk_if.walker_side walk,
   output logic mem_rd,
   output logic [`PA_WIDTH-1:0] mem_addr,
   input logic mem_rvalid,
   input logic [63:0] mem_rdata
);
   import mmu_pkg::*;

   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_WAIT
   } state_t;

   state_t r_state;
   logic [1:0] r_level, w_next_level;
   logic [`PA_WIDTH-13:0] w_ppn;
   logic w_v, w_r, w_w, w_x;
   logic w_leaf, w_misaligned, w_fault;

   // 9-bit vpn slice indexing the table at one level
   function automatic logic [8:0] vpn_field(input logic [`VA_WIDTH-1:0] v,
                                            input logic [1:0] lvl);
      logic [8:0] f;
      case (lvl)
         2'd2: f = v[`VA_WIDTH-1:30];
         2'd1: f = v[29:21];
         default: f = v[20:12];
      endcase
      return f;
   endfunction

   // pte fields, V R W X in the low bits, ppn from bit 10
   assign w_v = mem_rdata[0];
   assign w_r = mem_rdata[1];
   assign w_w = mem_rdata[2];
   assign w_x = mem_rdata[3];
   assign w_ppn = mem_rdata[53:10];
   assign w_leaf = w_r | w_x;
   assign w_next_level = r_level - 2'd1;

   // superpage leaves need the lower ppn fields clear
   assign w_misaligned = (r_level == 2'd2 && |w_ppn[17:0]) ||
                         (r_level == 2'd1 && |w_ppn[8:0]);

   assign w_fault = ~w_v | (w_w & ~w_r) | (w_leaf & w_misaligned) |
                    (~w_leaf & r_level == 2'd0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= ST_IDLE;
         r_level <= 2'd2;
         mem_rd <= 1'b0;
         walk.fill <= 1'b0;
         walk.fault <= 1'b0;
      end
      else
      begin
         mem_rd <= 1'b0;
         walk.fill <= 1'b0;
         walk.fault <= 1'b0;
         case (r_state)
            ST_IDLE:
            begin
               if (walk.miss)
               begin
                  mem_rd <= 1'b1;
                  r_level <= 2'd2;
                  r_state <= ST_WAIT;
               end
            end
            ST_WAIT:
            begin
               if (mem_rvalid)
               begin
                  if (w_fault | w_leaf)
                  begin
                     walk.fault <= w_fault;
                     walk.fill <= ~w_fault;
                     r_state <= ST_IDLE;
                  end
                  else
                  begin
                     // pointer, descend one level
                     mem_rd <= 1'b1;
                     r_level <= w_next_level;
                  end
               end
            end
            default: r_state <= ST_IDLE;
         endcase
      end
   end

   // miss_va is held by the tlb for the whole walk
   always_ff @(posedge clk)
   begin
      if (r_state == ST_IDLE && walk.miss)
         mem_addr <= {root_ppn, vpn_field(walk.miss_va, 2'd2), 3'b000};
      else if (r_state == ST_WAIT && mem_rvalid && !w_leaf)
         mem_addr <= {w_ppn, vpn_field(walk.miss_va, w_next_level), 3'b000};
      if (r_state == ST_WAIT && mem_rvalid && w_leaf)
      begin
         walk.fill_rsp.ppn <= w_ppn;
         walk.fill_rsp.pgsize <= pgsize_t'(2'd2 - r_level);
         walk.fill_rsp.dirty <= mem_rdata[7];
         walk.fill_rsp.readable <= w_r;
         walk.fill_rsp.writable <= w_w;
         walk.fill_rsp.executable <= w_x;
         walk.fill_rsp.user <= mem_rdata[4];
      end
   end

endmodule

/* run.sh */
#!/bin/sh
# build and run the mmu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mmu -f compile.f

./obj_dir/Vtb_mmu | tee sim.log

if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0

/* tb_mmu.sv */
`include "mmu_params.svh"

module tb_mmu;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [43:0] ROOT = 44'h100;

   logic clk = 1'b0;
   logic reset = 1'b1;
   logic active = 1'b0;
   logic clear = 1'b0;
   logic req = 1'b0;
   logic [`VA_WIDTH-1:0] va = '0;
   logic [`PA_WIDTH-13:0] root_ppn = ROOT;
   logic mem_rvalid = 1'b0;
   logic [63:0] mem_rdata = '0;
   logic busy, resp_valid, hit, fault, dirty, readable, writable, zero_page;
   logic mem_rd;
   logic [`PA_WIDTH-1:0] pa, mem_addr;
   logic [63:0] tlb_hits, tlb_accesses;

   integer seed = 32'h3336_c6c7;
   int errors = 0;
   int exp_acc = 0;
   int exp_hits = 0;
   logic [63:0] pt [logic [55:0]];
   logic [55:0] rd_log [$];
   logic [55:0] walk_addr [3];
   logic [26:0] c_tag [$];
   int c_lvl [$];

   mmu_top dut_i (.*);

   always #50 clk = ~clk;

   function automatic logic [63:0] mem_read(input logic [55:0] a);
      return pt.exists(a) ? pt[a] : 64'd0;
   endfunction

   function automatic logic [63:0] make_pte(input logic [43:0] ppn, input logic [9:0] fl);
      return {10'd0, ppn, fl};
   endfunction

   function automatic logic [38:0] make_va(input int i2, input int i1, input int i0,
                                           input int off);
      return {9'(i2), 9'(i1), 9'(i0), 12'(off)};
   endfunction

   // leaf flags with V and R set and W X D random
   function automatic logic [9:0] leaf_flags();
      return 10'h003 | (10'($random(seed) & 1) << 2) | (10'($random(seed) & 1) << 3) |
             (10'($random(seed) & 1) << 7);
   endfunction

   // reference walk that fills walk_addr and returns the read count
   function automatic int ref_walk(input logic [38:0] v, output bit flt,
                                   output logic [55:0] paddr, output logic [2:0] drw,
                                   output int lvl_out);
      logic [43:0] ppn;
      logic [63:0] p;
      logic [8:0] fld;
      int n;
      ppn = ROOT;
      n = 0;
      flt = 1'b1;
      paddr = '0;
      drw = '0;
      lvl_out = 0;
      for (int lvl = 2; lvl >= 0; lvl--)
      begin
         fld = (lvl == 2) ? v[38:30] : (lvl == 1) ? v[29:21] : v[20:12];
         walk_addr[n] = {ppn, fld, 3'b000};
         p = mem_read(walk_addr[n]);
         n++;
         if (!p[0] || (p[2] && !p[1]))
            return n;
         if (p[1] || p[3])
         begin
            if ((lvl == 2 && |p[27:10]) || (lvl == 1 && |p[18:10]))
               return n;
            flt = 1'b0;
            lvl_out = lvl;
            drw = {p[7], p[1], p[2]};
            if (lvl == 2)
               paddr = {p[53:28], v[29:0]};
            else if (lvl == 1)
               paddr = {p[53:19], v[20:0]};
            else
               paddr = {p[53:10], v[11:0]};
            return n;
         end
         if (lvl == 0)
            return n;
         ppn = p[53:10];
      end
      return n;
   endfunction

   function automatic bit cached(input logic [38:0] v);
      foreach (c_tag[i])
      begin
         if ((c_lvl[i] == 0 && c_tag[i] == v[38:12]) ||
             (c_lvl[i] == 1 && c_tag[i][26:9] == v[38:21]) ||
             (c_lvl[i] == 2 && c_tag[i][26:18] == v[38:30]))
            return 1'b1;
      end
      return 1'b0;
   endfunction

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         $display("[FAIL] %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   // memory port with one read outstanding at a time
   initial
   begin
      logic [55:0] a;
      int lat;
      forever
      begin
         @(negedge clk);
         if (mem_rd)
         begin
            a = mem_addr;
            rd_log.push_back(a);
            lat = 1 + ($random(seed) & 3);
            repeat (lat) @(posedge clk);
            #1;
            mem_rdata = mem_read(a);
            mem_rvalid = 1'b1;
            @(posedge clk);
            #1;
            mem_rvalid = 1'b0;
         end
      end
   end

   task automatic do_clear();
      @(posedge clk);
      #1 clear = 1'b1;
      @(posedge clk);
      #1 clear = 1'b0;
      c_tag.delete();
      c_lvl.delete();
   endtask

   // switch between translated and bare mode
   task automatic set_active(input logic a);
      @(posedge clk);
      #1 active = a;
   endtask

   task automatic run_req(input logic [38:0] v);
      bit flt, exp_hit, exp_walk;
      logic [55:0] epa;
      logic [2:0] edrw;
      int n, cyc, lvl;
      n = ref_walk(v, flt, epa, edrw, lvl);
      exp_hit = active ? cached(v) : 1'b1;
      exp_walk = active && !exp_hit;
      rd_log.delete();
      @(posedge clk);
      #1;
      req = 1'b1;
      va = v;
      @(posedge clk);
      #1 req = 1'b0;
      cyc = 0;
      do
      begin
         @(negedge clk);
         cyc++;
         if (cyc == 1)
            check_val("busy", exp_walk, busy);
         if (cyc > 200)
         begin
            $display("timeout waiting for resp_valid, va %h", v);
            $display("Test failed");
            $finish;
         end
      end
      while (!resp_valid);
      check_val("busy", 0, busy);
      check_val("zero_page", v[38:12] == 0, zero_page);
      if (!active)
      begin
         check_val("hit", 1, hit);
         check_val("fault", 0, fault);
         check_val("pa", {17'd0, v}, pa);
      end
      else
      begin
         check_val("hit", !flt, hit);
         check_val("fault", flt, fault);
         if (!flt)
         begin
            check_val("pa", epa, pa);
            check_val("dirty/readable/writable", edrw, {dirty, readable, writable});
         end
      end
      if (exp_hit && !(active && flt))
      begin
         check_val("latency", 1, cyc);
         check_val("mem_rd count", 0, rd_log.size());
      end
      else
      begin
         check_val("mem_rd count", n, rd_log.size());
         for (int i = 0; i < n && i < rd_log.size(); i++)
            check_val("mem_addr", walk_addr[i], rd_log[i]);
      end
      if (active)
      begin
         exp_acc++;
         if (exp_hit)
            exp_hits++;
         else if (!flt)
         begin
            c_tag.push_back(v[38:12]);
            c_lvl.push_back(lvl);
         end
      end
   endtask

   function automatic logic [38:0] pick_va(input int k);
      int r1, r0, off;
      r1 = $random(seed) & 511;
      r0 = $random(seed) & 511;
      off = $random(seed) & 4095;
      case (k)
         0: return make_va(1, 3, 10, off);
         1: return make_va(1, 3, 11, off);
         2: return make_va(1, 5, r0, off);
         3: return make_va(2, r1, r0, off);
         4: return make_va(1, 6, r0, off);
         5: return make_va(1, 7, r0, off);
         6: return make_va(3, r1, r0, off);
         7: return make_va(4, r1, r0, off);
         8: return make_va(1, 3, 12, off);
         9: return make_va(1, 3, 13, off);
         default: return make_va(0, 0, 0, off);
      endcase
   endfunction

   initial
   begin
      int k;
      // page table keyed by table ppn times 4096 plus index times 8
      pt[{ROOT, 9'd1, 3'b0}] = make_pte(44'h201, 10'h001);
      pt[{ROOT, 9'd2, 3'b0}] = make_pte({26'($random(seed)), 18'd0}, leaf_flags());
      pt[{ROOT, 9'd3, 3'b0}] = make_pte({26'($random(seed)), 18'h200}, leaf_flags());
      pt[{44'h201, 9'd3, 3'b0}] = make_pte(44'h301, 10'h001);
      pt[{44'h201, 9'd5, 3'b0}] = make_pte({35'($random(seed)), 9'd0}, leaf_flags());
      pt[{44'h201, 9'd6, 3'b0}] = make_pte({35'($random(seed)), 9'd1}, leaf_flags());
      pt[{44'h201, 9'd7, 3'b0}] = make_pte(44'($random(seed)), 10'h005);
      pt[{44'h301, 9'd10, 3'b0}] = make_pte({$random(seed), 12'($random(seed))}, leaf_flags());
      pt[{44'h301, 9'd11, 3'b0}] = make_pte({$random(seed), 12'($random(seed))}, leaf_flags());
      pt[{44'h301, 9'd12, 3'b0}] = make_pte(44'h123, 10'h001);
      pt[{44'h301, 9'd13, 3'b0}] = {$random(seed), 32'($random(seed)) & ~32'd1};
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;

      // bare mode
      run_req(39'($random(seed)));
      run_req('0);
      run_req(39'($random(seed)));
      set_active(1'b1);
      // each kind twice so faults walk again
      for (int i = 0; i <= 10; i++)
      begin
         run_req(pick_va(i));
         run_req(pick_va(i));
      end
      do_clear();
      run_req(pick_va(0));

      // random mix over at most four distinct valid pages
      for (int i = 0; i < 200; i++)
      begin
         k = $random(seed) & 15;
         if (k == 15)
            do_clear();
         else if (k >= 11)
         begin
            set_active(k != 14);
            run_req(pick_va($random(seed) & 3));
         end
         else
            run_req(pick_va(k));
      end
      @(negedge clk);
      check_val("tlb_accesses", exp_acc, tlb_accesses);
      check_val("tlb_hits", exp_hits, tlb_hits);
      $display("errors: %0d, accesses: %0d, hits: %0d", errors, exp_acc, exp_hits);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* tlb.sv */
`include "mmu_params.svh"

module tlb
#(
   parameter int LG_N = 2
)
(
   input logic clk,
   input logic reset,
   input logic active,
   input logic clear,
   input logic req,
   input logic [`VA_WIDTH-1:0] va,
   walk_if.tlb_side walk,
   output logic busy,
   output logic resp_valid,
   output logic hit,
   output logic fault,
   output logic [`PA_WIDTH-1:0] pa,
   output logic dirty,
   output logic readable,
   output logic writable,
   output logic zero_page,
   output logic [63:0] tlb_hits,
   output logic [63:0] tlb_accesses
);
   import mmu_pkg::*;

   localparam int N = 1 << LG_N;
   localparam int PPN_W = `PA_WIDTH - 12;
   localparam int VT = `VA_WIDTH - 1;

   logic [N-1:0] r_valid;
   logic [N-1:0] r_dirty, r_readable, r_writable;
   pgsize_t r_pgsize [N];
   logic [26:0] r_tag [N];
   logic [PPN_W-1:0] r_ppn [N];

   logic [N-1:0] w_hits;
   logic [LG_N-1:0] w_idx, w_free_idx, w_victim;
   logic w_any_hit, w_free_found;
   logic [15:0] r_lfsr;
   logic [`VA_WIDTH-1:0] r_pend_va, w_lookup_va;
   logic w_accept, w_miss_start;
   logic [PPN_W-1:0] w_ppn;
   pgsize_t w_pgsize;
   logic w_dirty, w_readable, w_writable;
   logic [`PA_WIDTH-1:0] w_pa_sel, w_bare_pa;

   // while a walk is pending, the held address is the one being translated
   assign w_lookup_va = busy ? r_pend_va : va;
   assign w_accept = req & ~busy;
   assign w_miss_start = w_accept & active & ~w_any_hit;
   assign w_bare_pa = {{(`PA_WIDTH-`VA_WIDTH){1'b0}}, w_lookup_va};
   assign walk.miss_va = r_pend_va;

   // superpages only compare the upper part of the tag
   always_comb
   begin
      for (int i = 0; i < N; i++)
      begin
         w_hits[i] = r_valid[i] &&
            ((r_pgsize[i] == PG_4K && r_tag[i] == w_lookup_va[VT:12]) ||
             (r_pgsize[i] == PG_2M && r_tag[i][26:9] == w_lookup_va[VT:21]) ||
             (r_pgsize[i] == PG_1G && r_tag[i][26:18] == w_lookup_va[VT:30]));
      end
   end

   find_first_set #(.LG_N(LG_N)) hit_ffs_i (.in(w_hits), .y(w_idx), .found(w_any_hit));

   // free slots first, random victim only once the tlb is full
   find_first_set #(.LG_N(LG_N)) free_ffs_i (.in(~r_valid), .y(w_free_idx),
                                             .found(w_free_found));

   assign w_victim = w_free_found ? w_free_idx : r_lfsr[LG_N:1];

   // on fill the new entry is forwarded, so the answer leaves one cycle later
   always_comb
   begin
      if (walk.fill)
      begin
         w_ppn = walk.fill_rsp.ppn;
         w_pgsize = walk.fill_rsp.pgsize;
         w_dirty = walk.fill_rsp.dirty;
         w_readable = walk.fill_rsp.readable;
         w_writable = walk.fill_rsp.writable;
      end
      else
      begin
         w_ppn = r_ppn[w_idx];
         w_pgsize = r_pgsize[w_idx];
         w_dirty = r_dirty[w_idx];
         w_readable = r_readable[w_idx];
         w_writable = r_writable[w_idx];
      end
      case (w_pgsize)
         PG_1G: w_pa_sel = {w_ppn[PPN_W-1:18], w_lookup_va[29:0]};
         PG_2M: w_pa_sel = {w_ppn[PPN_W-1:9], w_lookup_va[20:0]};
         default: w_pa_sel = {w_ppn, w_lookup_va[11:0]};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         resp_valid <= 1'b0;
         walk.miss <= 1'b0;
         r_lfsr <= 16'd1;
         tlb_hits <= '0;
         tlb_accesses <= '0;
      end
      else
      begin
         r_lfsr <= {r_lfsr[14:0], r_lfsr[15] ^ r_lfsr[13] ^ r_lfsr[12] ^ r_lfsr[10]};
         walk.miss <= w_miss_start;
         resp_valid <= (w_accept & (~active | w_any_hit)) | walk.fill | walk.fault;
         if (w_miss_start)
            busy <= 1'b1;
         else if (walk.fill | walk.fault)
            busy <= 1'b0;
         if (w_accept & active)
            tlb_accesses <= tlb_accesses + 64'd1;
         if (w_accept & active & w_any_hit)
            tlb_hits <= tlb_hits + 64'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (w_miss_start)
         r_pend_va <= va;
      if (w_accept | walk.fill | walk.fault)
      begin
         zero_page <= ~|w_lookup_va[VT:12];
         if (walk.fault)
         begin
            hit <= 1'b0;
            fault <= 1'b1;
            pa <= w_bare_pa;
            {dirty, readable, writable} <= 3'b000;
         end
         else if (~busy & ~active)
         begin
            // bare mode, no translation and no restriction
            hit <= 1'b1;
            fault <= 1'b0;
            pa <= w_bare_pa;
            {dirty, readable, writable} <= 3'b111;
         end
         else
         begin
            hit <= walk.fill | w_any_hit;
            fault <= 1'b0;
            pa <= w_pa_sel;
            {dirty, readable, writable} <= {w_dirty, w_readable, w_writable};
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset | clear)
         r_valid <= '0;
      else if (walk.fill)
         r_valid[w_victim] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (walk.fill)
      begin
         r_tag[w_victim] <= r_pend_va[VT:12];
         r_pgsize[w_victim] <= walk.fill_rsp.pgsize;
         r_ppn[w_victim] <= walk.fill_rsp.ppn;
         r_dirty[w_victim] <= walk.fill_rsp.dirty;
         r_readable[w_victim] <= walk.fill_rsp.readable;
         r_writable[w_victim] <= walk.fill_rsp.writable;
      end
   end

endmodule

/* walk_if.sv */
`include "mmu_params.svh"

interface walk_if;
   import mmu_pkg::*;

   // tlb to walker
   logic miss;
   logic [`VA_WIDTH-1:0] miss_va;

   // walker to tlb, exactly one of fill or fault ends a walk
   logic fill;
   page_walk_rsp_t fill_rsp;
   logic fault;

   modport tlb_side (output miss, output miss_va,
                     input fill, input fill_rsp, input fault);

   modport walker_side (input miss, input miss_va,
                        output fill, output fill_rsp, output fault);

endinterface
